/* divergence_stack.sv */
`include "sched_config.svh"
`default_nettype none

module divergence_stack import warp_ctl_pkg::*; (
    input  wire        clk,
    input  wire        reset,
    input  wire wctl_t warp_ctl,
    output join_t      dvg_join
);
    localparam int PTR_W = $clog2(`DVG_DEPTH + 1);
    localparam int IDX_W = $clog2(`DVG_DEPTH);

    typedef struct packed {
        logic                    is_dvg;
        logic                    is_else;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`PC_BITS-1:0]     pc;
    } dvg_entry_t;

    dvg_entry_t stack_mem [`NUM_WARPS][`DVG_DEPTH];
    logic [`NUM_WARPS-1:0][PTR_W-1:0] stack_ptr;

    logic             is_split;
    logic             is_join;
    logic             split_dvg;
    logic [PTR_W-1:0] ptr;
    logic [IDX_W-1:0] top_idx;
    dvg_entry_t       top;

    assign is_split  = warp_ctl.valid && (warp_ctl.op == WCTL_SPLIT);
    assign is_join   = warp_ctl.valid && (warp_ctl.op == WCTL_JOIN);
    assign split_dvg = (|warp_ctl.tmask) && (|warp_ctl.else_tmask);
    assign ptr       = stack_ptr[warp_ctl.wid];
    assign top_idx   = IDX_W'(ptr - PTR_W'(1));
    assign top       = stack_mem[warp_ctl.wid][top_idx];

    // divergent split pushes two entries, otherwise one marker
    always_ff @(posedge clk) begin
        if (reset) begin
            stack_ptr <= '0;
        end else if (is_split) begin
            stack_ptr[warp_ctl.wid] <= ptr + (split_dvg ? PTR_W'(2) : PTR_W'(1));
        end else if (is_join) begin
            stack_ptr[warp_ctl.wid] <= ptr - PTR_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (is_split) begin
            if (split_dvg) begin
                // restore entry below, else path on top
                stack_mem[warp_ctl.wid][IDX_W'(ptr)] <= '{1'b1, 1'b0,
                    warp_ctl.tmask | warp_ctl.else_tmask, `PC_BITS'(0)};
                stack_mem[warp_ctl.wid][IDX_W'(ptr + PTR_W'(1))] <= '{1'b1, 1'b1,
                    warp_ctl.else_tmask, warp_ctl.pc};
            end else begin
                stack_mem[warp_ctl.wid][IDX_W'(ptr)] <= '{1'b0, 1'b0,
                    `NUM_THREADS'(0), `PC_BITS'(0)};
            end
        end
    end

    // popped entry goes back in the join cycle
    assign dvg_join = '{
        valid:   is_join,
        is_dvg:  top.is_dvg,
        is_else: top.is_else,
        wid:     warp_ctl.wid,
        tmask:   top.tmask,
        pc:      top.pc
    };

endmodule

`default_nettype wire

/* pending_counter.sv */
`include "sched_config.svh"
`default_nettype none

module pending_counter (
    input  wire  clk,
    input  wire  reset,
    input  wire  incr,
    input  wire  decr,
    output logic empty
);
    logic [`PENDING_BITS-1:0] count;

    // incr and decr together leave the count alone
    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (incr && !decr) begin
            count <= count + `PENDING_BITS'(1);
        end else if (decr && !incr) begin
            count <= count - `PENDING_BITS'(1);
        end
    end

    assign empty = (count == '0);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_sched -f sources.f -o sim_sched \
    && ./obj_dir/sim_sched | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* sched_asserts.sv */
`include "sched_config.svh"
`default_nettype none

module sched_asserts import warp_ctl_pkg::*, sched_out_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire                  out_valid,
    input  wire                  out_ready,
    input  wire sched_entry_t    out_entry,
    input  wire [`NUM_WARPS-1:0] active_warps,
    input  wire wctl_t           warp_ctl
);
    timeunit 1ns;
    timeprecision 1ps;

    // held output must not change until taken
    a_out_hold: assert property (@(posedge clk) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_entry)))
        else $error("output entry changed while stalled");

    a_issue_active: assert property (@(posedge clk) disable iff (reset)
        (out_valid && out_ready) |-> active_warps[out_entry.wid])
        else $error("issue handed out for an inactive warp");

    a_ctl_active: assert property (@(posedge clk) disable iff (reset)
        warp_ctl.valid |-> active_warps[warp_ctl.wid])
        else $error("warp control targets an inactive warp");

endmodule

bind warp_schedule sched_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_entry    (out_entry),
    .active_warps (active_warps),
    .warp_ctl     (warp_ctl)
);

`default_nettype wire

/* sched_config.svh */
`ifndef SCHED_CONFIG_SVH
`define SCHED_CONFIG_SVH

// core geometry
`define NUM_WARPS    4
`define NUM_THREADS  4
`define PC_BITS      16

// local barriers
`define NUM_BARRIERS 2

// reconvergence entries per warp
`define DVG_DEPTH    4

// uncommitted instruction counter width
`define PENDING_BITS 8

// derived index widths
`define NW_WIDTH     2
`define NB_WIDTH     1

`endif

/* sched_out_buffer.sv */
`default_nettype none

module sched_out_buffer import sched_out_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire               in_valid,
    input  wire sched_entry_t in_entry,
    output logic              in_ready,
    output logic              out_valid,
    output sched_entry_t      out_entry,
    input  wire               out_ready
);
    logic         skid_valid;
    sched_entry_t skid_entry;
    logic         in_fire;
    logic         out_load;

    // full once the skid slot holds an entry
    assign in_ready = !skid_valid;
    assign in_fire  = in_valid && in_ready;
    // output register free or emptying this cycle
    assign out_load = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            out_valid  <= skid_valid || in_valid;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (out_load) begin
            // older skid entry goes out first
            if (skid_valid) begin
                out_entry <= skid_entry;
            end else if (in_valid) begin
                out_entry <= in_entry;
            end
        end else if (in_fire) begin
            skid_entry <= in_entry;
        end
    end

endmodule

`default_nettype wire

/* sched_out_pkg.sv */
`include "sched_config.svh"
`default_nettype none

package sched_out_pkg;

    // one issued instruction slot
    typedef struct packed {
        logic [`NW_WIDTH-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`PC_BITS-1:0]     pc;
    } sched_entry_t;

    // busy is one cycle behind the state it reflects
    typedef struct packed {
        logic                  busy;
        logic [`NUM_WARPS-1:0] active_warps;
    } sched_status_t;

endpackage

`default_nettype wire

/* sched_top.sv */
`include "sched_config.svh"
`default_nettype none

module sched_top import warp_ctl_pkg::*, sched_out_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [`PC_BITS-1:0]   startup_pc,
    input  wire wctl_t           warp_ctl,
    input  wire branch_t         branch,
    input  wire unlock_t         unlock,
    // one pulse per committed instruction
    input  wire [`NUM_WARPS-1:0] committed,
    input  wire                  out_ready,
    output logic                 out_valid,
    output sched_entry_t         out_entry,
    output sched_status_t        status
);

    warp_schedule u_sched (
        .clk        (clk),
        .reset      (reset),
        .startup_pc (startup_pc),
        .warp_ctl   (warp_ctl),
        .branch     (branch),
        .unlock     (unlock),
        .committed  (committed),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .status     (status)
    );

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
warp_ctl_pkg.sv
sched_out_pkg.sv
divergence_stack.sv
pending_counter.sv
sched_out_buffer.sv
warp_schedule.sv
sched_top.sv
sched_asserts.sv
tb_sched.sv

/* tb_sched.sv */
`include "sched_config.svh"
`default_nettype none

module tb_sched import warp_ctl_pkg::*, sched_out_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NW = `NUM_WARPS;
    localparam int NT = `NUM_THREADS;

    typedef struct packed {
        logic                is_dvg;
        logic                is_else;
        logic [NT-1:0]       tmask;
        logic [`PC_BITS-1:0] pc;
    } stk_t;

    logic                clk;
    logic                reset;
    logic [`PC_BITS-1:0] startup_pc;
    wctl_t               warp_ctl;
    branch_t             branch;
    unlock_t             unlock;
    logic [NW-1:0]       committed;
    logic                out_ready;
    logic                out_valid;
    sched_entry_t        out_entry;
    sched_status_t       status;

    // reference model of every warp
    logic [NW-1:0]       m_active;
    logic [NW-1:0]       m_busy;
    logic [NT-1:0]       m_tmask [NW];
    logic [`PC_BITS-1:0] m_pc [NW];
    stk_t                stk [NW][`DVG_DEPTH];
    int                  sp [NW];
    logic                spawn_due;
    logic [NW-1:0]       spawn_mask;
    logic [`PC_BITS-1:0] spawn_pc;
    int                  spawn_wid;
    logic                bar_on;
    logic [NW-1:0]       bar_wait;
    logic [`NB_WIDTH-1:0] bar_id_m;
    logic [`NW_WIDTH-1:0] bar_size_m;
    int                  bar_cnt;
    logic [NW-1:0]       hist [3];
    logic                bhist [3];
    int                  rq_wid [$];
    int                  rq_due [$];
    int                  cq_wid [$];
    int                  cq_due [$];
    int                  outstanding;
    int                  idle [NW];
    int                  cyc, fires, errors, checks, low_left, t;
    logic                stopping;
    sched_status_t       last_status;

    sched_top DUT (
        .clk        (clk),
        .reset      (reset),
        .startup_pc (startup_pc),
        .warp_ctl   (warp_ctl),
        .branch     (branch),
        .unlock     (unlock),
        .committed  (committed),
        .out_ready  (out_ready),
        .out_valid  (out_valid),
        .out_entry  (out_entry),
        .status     (status)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_entry(input sched_entry_t act, input sched_entry_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED out_entry: got %h expected %h", act, exp);
        end
    endtask

    task automatic check_status(input sched_status_t act, input sched_status_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("FAILED status: got %h expected %h", act, exp);
        end
    endtask

    // pick a random resolving control for warp w and update the model
    task automatic resolve(input int w, output wctl_t wc, output branch_t br,
                           output unlock_t ul);
        int            kind;
        logic [NT-1:0] cur;
        logic [NT-1:0] then_m;
        logic [NT-1:0] else_m;
        stk_t          e;
        wc = '0;
        br = '0;
        ul = '0;
        kind = int'($urandom_range(0, 9));
        if (bar_on) kind = 9;
        else if (stopping) kind = 10;
        if (kind == 5 && !($countones(m_active) == 1 && !spawn_due)) kind = 2;
        if ((kind == 6 || kind == 7) && sp[w] > `DVG_DEPTH - 2) kind = 2;
        if (kind == 8 && sp[w] == 0) kind = 2;
        m_busy[w] = 1'b0;
        wc.wid = `NW_WIDTH'(w);
        case (kind)
            0, 1: begin
                br.valid = 1'b1;
                br.wid   = `NW_WIDTH'(w);
                br.taken = 1'($urandom_range(0, 1));
                br.dest  = `PC_BITS'($urandom);
                if (br.taken) m_pc[w] = br.dest;
            end
            3, 4, 10: begin
                wc.valid = 1'b1;
                wc.op    = WCTL_TMC;
                wc.tmask = NT'($urandom_range(1, (1 << NT) - 1));
                if (kind == 10 || ($countones(m_active) > 1 && $urandom_range(0, 7) == 0))
                    wc.tmask = '0;
                m_tmask[w] = wc.tmask;
                if (wc.tmask == '0) m_active[w] = 1'b0;
            end
            5: begin
                wc.valid   = 1'b1;
                wc.op      = WCTL_WSPAWN;
                spawn_mask = NW'($urandom) & ~(NW'(1) << w);
                if (spawn_mask == '0) spawn_mask = NW'(1) << ((w + 1) % NW);
                wc.tmask[NW-1:0] = spawn_mask;
                wc.pc      = `PC_BITS'($urandom);
                spawn_pc   = wc.pc;
                spawn_wid  = w;
                spawn_due  = 1'b1;
                // spawner waits until the spawn is applied
                m_busy[w]  = 1'b1;
            end
            6, 7: begin
                cur    = m_tmask[w];
                then_m = cur & NT'($urandom);
                else_m = cur & ~then_m;
                wc.valid      = 1'b1;
                wc.op         = WCTL_SPLIT;
                wc.tmask      = then_m;
                wc.else_tmask = else_m;
                wc.pc         = `PC_BITS'($urandom);
                if (then_m != '0 && else_m != '0) begin
                    stk[w][sp[w]]     = '{1'b1, 1'b0, cur, `PC_BITS'(0)};
                    stk[w][sp[w] + 1] = '{1'b1, 1'b1, else_m, wc.pc};
                    sp[w] += 2;
                    m_tmask[w] = then_m;
                end else begin
                    stk[w][sp[w]] = '0;
                    sp[w] += 1;
                end
            end
            8: begin
                wc.valid = 1'b1;
                wc.op    = WCTL_JOIN;
                sp[w] -= 1;
                e = stk[w][sp[w]];
                if (e.is_dvg) m_tmask[w] = e.tmask;
                if (e.is_dvg && e.is_else) m_pc[w] = e.pc;
            end
            9: begin
                if (!bar_on) begin
                    bar_on     = 1'b1;
                    bar_id_m   = `NB_WIDTH'($urandom_range(0, `NUM_BARRIERS - 1));
                    bar_size_m = `NW_WIDTH'($countones(m_active) - 1);
                    bar_cnt    = 0;
                end
                wc.valid       = 1'b1;
                wc.op          = WCTL_BAR;
                wc.bar_id      = bar_id_m;
                wc.bar_size_m1 = bar_size_m;
                if (bar_cnt == int'(bar_size_m)) begin
                    m_busy   = m_busy & ~bar_wait;
                    bar_wait = '0;
                    bar_on   = 1'b0;
                end else begin
                    bar_wait[w] = 1'b1;
                    m_busy[w]   = 1'b1;
                    bar_cnt++;
                end
            end
            default: begin
                ul.valid = 1'b1;
                ul.wid   = `NW_WIDTH'(w);
            end
        endcase
    endtask

    // sample at negedge, drive at the following posedge
    task automatic step_cycle();
        sched_entry_t  exp_e;
        wctl_t         wc;
        branch_t       br;
        unlock_t       ul;
        logic [NW-1:0] cm;
        logic          rdy;
        int            w;
        @(negedge clk);
        cyc++;
        last_status = status;
        // busy while a warp runs or a commit is still owed
        if (bhist[2]) check_status(status, '{busy: 1'b1, active_warps: hist[1]});
        if (spawn_due) begin
            for (int i = 0; i < NW; i++) begin
                if (spawn_mask[i]) begin
                    m_active[i] = 1'b1;
                    m_tmask[i]  = NT'(1);
                    m_pc[i]     = spawn_pc;
                end
            end
            m_busy[spawn_wid] = 1'b0;
            spawn_due = 1'b0;
        end
        if (out_valid && out_ready) begin
            w = int'(out_entry.wid);
            if (!m_active[w] || m_busy[w]) begin
                errors++;
                $display("warp %0d issued while inactive or still outstanding", w);
            end
            exp_e = '{wid: `NW_WIDTH'(w), tmask: m_tmask[w], pc: m_pc[w]};
            check_entry(out_entry, exp_e);
            m_pc[w]   = m_pc[w] + `PC_BITS'(1);
            m_busy[w] = 1'b1;
            fires++;
            outstanding++;
            rq_wid.push_back(w);
            rq_due.push_back(cyc + int'($urandom_range(0, 5)));
        end
        cm = '0;
        wc = '0;
        br = '0;
        ul = '0;
        if (rq_wid.size() > 0 && rq_due[0] <= cyc) begin
            w = rq_wid.pop_front();
            void'(rq_due.pop_front());
            resolve(w, wc, br, ul);
            // commit trails the resolve by a few cycles
            cq_wid.push_back(w);
            cq_due.push_back(cyc + int'($urandom_range(1, 6)));
        end
        if (cq_wid.size() > 0 && cq_due[0] <= cyc) begin
            w = cq_wid.pop_front();
            void'(cq_due.pop_front());
            cm[w] = 1'b1;
            outstanding--;
        end
        // occasional long stretches of back-pressure
        if (low_left > 0) begin
            rdy = 1'b0;
            low_left--;
        end else if ($urandom_range(0, 31) == 0) begin
            rdy = 1'b0;
            low_left = int'($urandom_range(10, 30));
        end else begin
            rdy = ($urandom_range(0, 3) != 0);
        end
        for (int i = 0; i < NW; i++) begin
            idle[i] = (m_active[i] && !m_busy[i]) ? idle[i] + 1 : 0;
            if (idle[i] == 3000) begin
                errors++;
                $display("warp %0d was ready but never issued", i);
            end
        end
        hist[2] = hist[1];
        hist[1] = hist[0];
        hist[0] = m_active;
        bhist[2] = bhist[1];
        bhist[1] = bhist[0];
        bhist[0] = (m_active != '0) || (outstanding > 0);
        @(posedge clk);
        warp_ctl  <= wc;
        branch    <= br;
        unlock    <= ul;
        committed <= cm;
        out_ready <= rdy;
    endtask

    initial begin
        void'($urandom(32'h7a4));
        reset      = 1'b1;
        startup_pc = `PC_BITS'($urandom);
        warp_ctl   = '0;
        branch     = '0;
        unlock     = '0;
        committed  = '0;
        out_ready  = 1'b0;
        m_active   = NW'(1);
        m_busy     = '0;
        for (int i = 0; i < NW; i++) begin
            m_tmask[i] = '0;
            m_pc[i]    = '0;
            sp[i]      = 0;
            idle[i]    = 0;
        end
        m_tmask[0] = NT'(1);
        m_pc[0]    = startup_pc;
        spawn_due  = 1'b0;
        bar_on     = 1'b0;
        bar_wait   = '0;
        hist[0]    = '0;
        hist[1]    = '0;
        hist[2]    = '0;
        bhist[0]   = 1'b0;
        bhist[1]   = 1'b0;
        bhist[2]   = 1'b0;
        outstanding = 0;
        stopping   = 1'b0;
        cyc = 0;
        fires = 0;
        errors = 0;
        checks = 0;
        low_left = 0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        while (fires < 400 && cyc < 30000) step_cycle();
        if (fires < 400) begin
            errors++;
            $display("timed out waiting for issues");
        end

        // retire every warp with a zero-mask TMC
        stopping = 1'b1;
        t = 0;
        while ((m_active != '0 || rq_wid.size() > 0 || cq_wid.size() > 0) && t < 5000) begin
            step_cycle();
            t++;
        end
        if (t >= 5000) begin
            errors++;
            $display("timed out waiting for all warps to retire");
        end

        t = 0;
        step_cycle();
        while (last_status.busy && t < 20) begin
            step_cycle();
            t++;
        end
        if (last_status.busy) begin
            errors++;
            $display("busy did not fall after all warps retired");
        end
        check_status(last_status, '{busy: 1'b0, active_warps: '0});

        $display("errors: %0d, checks: %0d, issues: %0d", errors, checks, fires);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* warp_ctl_pkg.sv */
`include "sched_config.svh"
`default_nettype none

package warp_ctl_pkg;

    // warp control operations, one per cycle at most
    typedef enum logic [2:0] {
        WCTL_TMC,
        WCTL_WSPAWN,
        WCTL_SPLIT,
        WCTL_JOIN,
        WCTL_BAR
    } wctl_op_e;

    typedef struct packed {
        logic                    valid;
        logic [`NW_WIDTH-1:0]    wid;
        wctl_op_e                op;
        // new tmask, then-mask for split, warp mask for wspawn
        logic [`NUM_THREADS-1:0] tmask;
        logic [`NUM_THREADS-1:0] else_tmask;
        // spawn start pc or else pc
        logic [`PC_BITS-1:0]     pc;
        logic [`NB_WIDTH-1:0]    bar_id;
        logic [`NW_WIDTH-1:0]    bar_size_m1;
    } wctl_t;

    typedef struct packed {
        logic                 valid;
        logic [`NW_WIDTH-1:0] wid;
        logic                 taken;
        logic [`PC_BITS-1:0]  dest;
    } branch_t;

    typedef struct packed {
        logic                 valid;
        logic [`NW_WIDTH-1:0] wid;
    } unlock_t;

    // popped reconvergence entry
    typedef struct packed {
        logic                    valid;
        logic                    is_dvg;
        logic                    is_else;
        logic [`NW_WIDTH-1:0]    wid;
        logic [`NUM_THREADS-1:0] tmask;
        logic [`PC_BITS-1:0]     pc;
    } join_t;

endpackage

`default_nettype wire

/* warp_schedule.sv */
`include "sched_config.svh"
`default_nettype none

module warp_schedule import warp_ctl_pkg::*, sched_out_pkg::*; (
    input  wire                  clk,
    input  wire                  reset,
    input  wire [`PC_BITS-1:0]   startup_pc,
    input  wire wctl_t           warp_ctl,
    input  wire branch_t         branch,
    input  wire unlock_t         unlock,
    input  wire [`NUM_WARPS-1:0] committed,
    input  wire                  out_ready,
    output logic                 out_valid,
    output sched_entry_t         out_entry,
    output sched_status_t        status
);
    logic [`NUM_WARPS-1:0] active_warps;
    logic [`NUM_WARPS-1:0] active_warps_n;
    logic [`NUM_WARPS-1:0] stalled_warps;
    logic [`NUM_WARPS-1:0] stalled_warps_n;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] thread_masks;
    logic [`NUM_WARPS-1:0][`NUM_THREADS-1:0] thread_masks_n;
    logic [`NUM_WARPS-1:0][`PC_BITS-1:0] warp_pcs;
    logic [`NUM_WARPS-1:0][`PC_BITS-1:0] warp_pcs_n;
    logic [`NUM_BARRIERS-1:0][`NUM_WARPS-1:0] barrier_masks;
    logic [`NUM_BARRIERS-1:0][`NUM_WARPS-1:0] barrier_masks_n;
    logic [`NUM_BARRIERS-1:0][`NW_WIDTH-1:0] barrier_ctrs;
    logic [`NUM_BARRIERS-1:0][`NW_WIDTH-1:0] barrier_ctrs_n;

    // pending wspawn request
    logic                  wspawn_valid;
    logic [`NUM_WARPS-1:0] wspawn_wmask;
    logic [`PC_BITS-1:0]   wspawn_pc;
    logic [`NW_WIDTH-1:0]  wspawn_wid;
    logic                  is_single_warp;
    logic                  wspawn_apply;

    join_t                 dvg_join;
    logic [`NUM_WARPS-1:0] ready_warps;
    logic                  sched_valid;
    logic                  sched_ready;
    logic                  sched_fire;
    logic [`NW_WIDTH-1:0]  sched_wid;
    sched_entry_t          sched_entry;
    logic                  out_fire;
    logic [`NUM_WARPS-1:0] pending_empty;
    logic                  busy;

    assign is_single_warp = ($countones(active_warps) == 1);
    assign wspawn_apply   = wspawn_valid && is_single_warp;
    assign out_fire       = out_valid && out_ready;

    always_comb begin
        active_warps_n  = active_warps;
        stalled_warps_n = stalled_warps;
        thread_masks_n  = thread_masks;
        warp_pcs_n      = warp_pcs;
        barrier_masks_n = barrier_masks;
        barrier_ctrs_n  = barrier_ctrs;

        if (wspawn_apply) begin
            active_warps_n = active_warps_n | wspawn_wmask;
            for (int i = 0; i < `NUM_WARPS; i++) begin
                if (wspawn_wmask[i]) begin
                    thread_masks_n[i] = `NUM_THREADS'(1);
                    warp_pcs_n[i]     = wspawn_pc;
                end
            end
            stalled_warps_n[wspawn_wid] = 1'b0;
        end

        if (warp_ctl.valid) begin
            case (warp_ctl.op)
                WCTL_TMC: begin
                    active_warps_n[warp_ctl.wid]  = |warp_ctl.tmask;
                    thread_masks_n[warp_ctl.wid]  = warp_ctl.tmask;
                    stalled_warps_n[warp_ctl.wid] = 1'b0;
                end
                WCTL_SPLIT: begin
                    // then mask only when both sides have threads
                    if ((|warp_ctl.tmask) && (|warp_ctl.else_tmask)) begin
                        thread_masks_n[warp_ctl.wid] = warp_ctl.tmask;
                    end
                    stalled_warps_n[warp_ctl.wid] = 1'b0;
                end
                WCTL_BAR: begin
                    if (barrier_ctrs[warp_ctl.bar_id] == warp_ctl.bar_size_m1) begin
                        // last arrival releases the whole group
                        barrier_ctrs_n[warp_ctl.bar_id]  = '0;
                        barrier_masks_n[warp_ctl.bar_id] = '0;
                        stalled_warps_n = stalled_warps_n & ~barrier_masks[warp_ctl.bar_id];
                        stalled_warps_n[warp_ctl.wid] = 1'b0;
                    end else begin
                        barrier_ctrs_n[warp_ctl.bar_id] =
                            barrier_ctrs[warp_ctl.bar_id] + `NW_WIDTH'(1);
                        barrier_masks_n[warp_ctl.bar_id] = barrier_masks[warp_ctl.bar_id]
                            | (`NUM_WARPS'(1) << warp_ctl.wid);
                    end
                end
                // wspawn is latched, join returns through the stack
                default: begin
                end
            endcase
        end

        if (dvg_join.valid) begin
            if (dvg_join.is_dvg) begin
                if (dvg_join.is_else) begin
                    warp_pcs_n[dvg_join.wid] = dvg_join.pc;
                end
                thread_masks_n[dvg_join.wid] = dvg_join.tmask;
            end
            stalled_warps_n[dvg_join.wid] = 1'b0;
        end

        if (branch.valid) begin
            if (branch.taken) begin
                warp_pcs_n[branch.wid] = branch.dest;
            end
            stalled_warps_n[branch.wid] = 1'b0;
        end

        if (unlock.valid) begin
            stalled_warps_n[unlock.wid] = 1'b0;
        end

        // hold the picked warp until its instruction resolves
        if (sched_fire) begin
            stalled_warps_n[sched_wid] = 1'b1;
        end
        if (out_fire) begin
            warp_pcs_n[out_entry.wid] = out_entry.pc + `PC_BITS'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            active_warps    <= `NUM_WARPS'(1);
            stalled_warps   <= '0;
            thread_masks    <= '0;
            thread_masks[0] <= `NUM_THREADS'(1);
            warp_pcs        <= '0;
            warp_pcs[0]     <= startup_pc;
            barrier_masks   <= '0;
            barrier_ctrs    <= '0;
            wspawn_valid    <= 1'b0;
            busy            <= 1'b0;
        end else begin
            active_warps  <= active_warps_n;
            stalled_warps <= stalled_warps_n;
            thread_masks  <= thread_masks_n;
            warp_pcs      <= warp_pcs_n;
            barrier_masks <= barrier_masks_n;
            barrier_ctrs  <= barrier_ctrs_n;
            // a new request wins over the one being applied
            if (warp_ctl.valid && (warp_ctl.op == WCTL_WSPAWN)) begin
                wspawn_valid <= 1'b1;
            end else if (wspawn_apply) begin
                wspawn_valid <= 1'b0;
            end
            busy <= (|active_warps) || !(&pending_empty);
        end
    end

    always_ff @(posedge clk) begin
        if (warp_ctl.valid && (warp_ctl.op == WCTL_WSPAWN)) begin
            wspawn_wmask <= warp_ctl.tmask[`NUM_WARPS-1:0];
            wspawn_pc    <= warp_ctl.pc;
            wspawn_wid   <= warp_ctl.wid;
        end
    end

    divergence_stack u_dvg_stack (
        .clk      (clk),
        .reset    (reset),
        .warp_ctl (warp_ctl),
        .dvg_join (dvg_join)
    );

    // lowest-numbered ready warp
    assign ready_warps = active_warps & ~stalled_warps;
    assign sched_valid = |ready_warps;
    assign sched_fire  = sched_valid && sched_ready;

    always_comb begin
        sched_wid = '0;
        for (int i = `NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                sched_wid = `NW_WIDTH'(i);
            end
        end
    end

    assign sched_entry = '{
        wid:   sched_wid,
        tmask: thread_masks[sched_wid],
        pc:    warp_pcs[sched_wid]
    };

    sched_out_buffer u_out_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sched_valid),
        .in_entry  (sched_entry),
        .in_ready  (sched_ready),
        .out_valid (out_valid),
        .out_entry (out_entry),
        .out_ready (out_ready)
    );

    for (genvar i = 0; i < `NUM_WARPS; i++) begin : g_pending
        pending_counter u_pending (
            .clk   (clk),
            .reset (reset),
            .incr  (out_fire && (out_entry.wid == `NW_WIDTH'(i))),
            .decr  (committed[i]),
            .empty (pending_empty[i])
        );
    end

    assign status = '{busy: busy, active_warps: active_warps};

endmodule

`default_nettype wire
